/* source/strm_config.svh */
`ifndef STRM_CONFIG_SVH
`define STRM_CONFIG_SVH

// ====================
// stream read channel sizing
// ====================

`define STRM_DAT_BITS 64        // one strip of memory data
`define STRM_FIFO_AW 4          // log2 of the crossing FIFO depth, 16 records
`define STRM_CNT_BITS 8         // strips per request, up to 255

// flops in each pointer synchronizer
`define STRM_SYNC_STAGES 2

// burst response tag, transaction 0 of the fixed stream master
`define STRM_TID 13'h1f80

`endif

/* source/strm_pkg.sv */
package strm_pkg;

`include "strm_config.svh"

   // ====================
   // request side
   // ====================

   // base address plus the number of strips to stream
   typedef struct packed {
      logic [31:0]               adr;
      logic [`STRM_CNT_BITS-1:0] strips;   // zero means no request
   } strm_req_t;

   // ====================
   // response side
   // ====================

   // one record per strip, as seen by the consumer in the rclk domain
   typedef struct packed {
      logic                      ack;   // record is valid this cycle
      logic                      last;  // final strip of the stream
      logic [12:0]               tid;
      logic [31:0]               adr;
      logic [`STRM_DAT_BITS-1:0] dat;
   } strm_resp_t;

   // strip sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE,    // waiting for a request, busy is low
      SEQ_ISSUE,   // sending reads to memory under the credit limit
      SEQ_DRAIN    // all reads sent, waiting for the last return
   } seq_state_e;

endpackage

/* source/strm_strip_cnt.sv */
`include "strm_config.svh"

module strm_strip_cnt (
   input  logic                   rst,
   input  logic                   wclk,
   input  logic                   load,             // sequencer accepted req this cycle
   input  strm_pkg::strm_req_t    req,
   input  logic                   issue,            // one memory read sent
   input  logic                   mem_valid,        // one strip came back
   output logic                   issue_left_zero,
   output logic                   ret_left_zero,
   output logic [`STRM_FIFO_AW:0] in_flight,
   output logic [31:0]            ret_adr,          // address of the strip now returning
   output logic                   last_strip
);

   localparam logic [31:0] STEP = 32'(`STRM_DAT_BITS / 8);   // bytes per strip

   logic [`STRM_CNT_BITS-1:0] issue_cnt;   // reads still to send
   logic [`STRM_CNT_BITS-1:0] ret_cnt;     // strips still to come back

   always_ff @(posedge wclk) begin
      if (rst) begin
         issue_cnt <= '0;
         ret_cnt   <= '0;
         in_flight <= '0;
      end else begin
         if (load) begin
            issue_cnt <= req.strips;
            ret_cnt   <= req.strips;
         end else begin
            if (issue)
               issue_cnt <= issue_cnt - 1'b1;
            if (mem_valid)
               ret_cnt <= ret_cnt - 1'b1;
         end
         // an issue and a return in the same cycle cancel out
         case ({issue, mem_valid})
            2'b10:   in_flight <= in_flight + 1'b1;
            2'b01:   in_flight <= in_flight - 1'b1;
            default: ;
         endcase
      end
   end

   // memory answers in order so the return address just walks up from the base
   always_ff @(posedge wclk) begin
      if (load)
         ret_adr <= req.adr;
      else if (mem_valid)
         ret_adr <= ret_adr + STEP;
   end

   assign issue_left_zero = (issue_cnt == '0);
   assign ret_left_zero   = (ret_cnt == '0);
   assign last_strip      = (ret_cnt == `STRM_CNT_BITS'(1));  // valid during the final beat

   // the sequencer and the memory must never run a count below zero
   a_issue_underflow : assert property (@(posedge wclk) disable iff (rst)
      issue && !load |-> issue_cnt != '0);
   a_ret_underflow : assert property (@(posedge wclk) disable iff (rst)
      mem_valid && !load |-> ret_cnt != '0);

endmodule

/* source/strm_strip_seq.sv */
`include "strm_config.svh"

module strm_strip_seq (
   input  logic                   rst,
   input  logic                   wclk,
   input  logic                   req_valid,
   input  strm_pkg::strm_req_t    req,
   input  logic [`STRM_FIFO_AW:0] in_flight,
   input  logic [`STRM_FIFO_AW:0] wr_count,        // FIFO occupancy seen from the write side
   input  logic                   issue_left_zero,
   input  logic                   ret_left_zero,
   input  logic                   mem_valid,
   output logic                   load,
   output logic                   issue,
   output logic                   mem_rd,
   output logic [31:0]            mem_adr,
   output logic                   busy
);

   localparam int          DEPTH = 1 << `STRM_FIFO_AW;
   localparam logic [31:0] STEP  = 32'(`STRM_DAT_BITS / 8);

   strm_pkg::seq_state_e state;
   strm_pkg::seq_state_e state_nxt;
   logic [31:0]             issue_adr;    // address of the next read
   logic                    ret_pend;     // a returned strip sits in the record latch
   logic [`STRM_FIFO_AW+1:0] credit_used;
   logic                    credit_ok;

   // ====================
   // credit check
   // ====================

   // every strip already asked for holds a FIFO slot, whether it is still in memory,
   // in the record latch or in the FIFO itself
   assign credit_used = {1'b0, in_flight} + {1'b0, wr_count} + {{`STRM_FIFO_AW+1{1'b0}}, ret_pend};
   assign credit_ok   = credit_used < (`STRM_FIFO_AW+2)'(DEPTH);

   assign load   = (state == strm_pkg::SEQ_IDLE) && req_valid && (req.strips != '0);
   assign issue  = (state == strm_pkg::SEQ_ISSUE) && !issue_left_zero && credit_ok;
   assign mem_rd = issue;
   assign mem_adr = issue_adr;
   assign busy   = (state != strm_pkg::SEQ_IDLE);   // rises the cycle after load

   // ====================
   // state machine
   // ====================

   always_comb begin
      state_nxt = state;
      case (state)
         strm_pkg::SEQ_IDLE:  if (load) state_nxt = strm_pkg::SEQ_ISSUE;
         strm_pkg::SEQ_ISSUE: if (issue_left_zero) state_nxt = strm_pkg::SEQ_DRAIN;
         // leave only once the last strip has also passed the latch into the FIFO
         strm_pkg::SEQ_DRAIN: if (ret_left_zero && !ret_pend) state_nxt = strm_pkg::SEQ_IDLE;
         default:             state_nxt = strm_pkg::SEQ_IDLE;
      endcase
   end

   always_ff @(posedge wclk) begin
      if (rst) begin
         state    <= strm_pkg::SEQ_IDLE;
         ret_pend <= 1'b0;
      end else begin
         state    <= state_nxt;
         ret_pend <= mem_valid;   // mirrors the one cycle latch in the read FIFO
      end
   end

   always_ff @(posedge wclk) begin
      if (load)
         issue_adr <= req.adr;
      else if (issue)
         issue_adr <= issue_adr + STEP;   // strips go out in ascending order
   end

   // going idle with reads still out would strand their returns
   a_idle_drained : assert property (@(posedge wclk) disable iff (rst)
      state == strm_pkg::SEQ_DRAIN && state_nxt == strm_pkg::SEQ_IDLE |-> in_flight == '0);
   // reads outstanding plus records queued never exceed what the FIFO can hold
   a_credit_limit : assert property (@(posedge wclk) disable iff (rst)
      ({1'b0, in_flight} + {1'b0, wr_count}) <= (`STRM_FIFO_AW+2)'(DEPTH));

endmodule

/* source/strm_async_fifo.sv */
`include "strm_config.svh"

module strm_async_fifo (
   input  logic                   rst,
   input  logic                   wclk,
   input  logic                   wr_en,
   input  strm_pkg::strm_resp_t   din,
   input  logic                   rclk,
   input  logic                   rd_en,
   output logic                   full,
   output logic [`STRM_FIFO_AW:0] wr_count,   // pessimistic, the read pointer arrives late
   output logic                   empty,
   output strm_pkg::strm_resp_t   dout,
   output logic                   data_valid
);

   localparam int AW    = `STRM_FIFO_AW;
   localparam int DEPTH = 1 << AW;
   localparam int NSYNC = `STRM_SYNC_STAGES;

   strm_pkg::strm_resp_t mem [DEPTH];

   logic [AW:0] wbin;                    // write pointer, extra bit tells full from empty
   logic [AW:0] wbin_nxt;
   logic [AW:0] wgray;
   logic [AW:0] rgray_sync [NSYNC];      // read pointer brought into wclk
   logic [AW:0] rbin_w;
   logic        wr_ok;

   logic [AW:0] rbin;
   logic [AW:0] rbin_nxt;
   logic [AW:0] rgray;
   logic [AW:0] wgray_sync [NSYNC];      // write pointer brought into rclk
   logic        rd_ok;

   function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--)
         b[i] = b[i+1] ^ g[i];
      return b;
   endfunction

   // ====================
   // write domain
   // ====================

   assign wr_ok    = wr_en && !full;   // a write into a full FIFO is dropped
   assign wbin_nxt = wbin + {{AW{1'b0}}, wr_ok};
   assign rbin_w   = gray2bin(rgray_sync[NSYNC-1]);
   assign wr_count = wbin - rbin_w;
   assign full     = (wr_count == (AW+1)'(DEPTH));

   always_ff @(posedge wclk) begin
      if (rst) begin
         wbin  <= '0;
         wgray <= '0;
         for (int i = 0; i < NSYNC; i++)
            rgray_sync[i] <= '0;
      end else begin
         wbin  <= wbin_nxt;
         wgray <= bin2gray(wbin_nxt);   // only one bit flips per step, safe to sample
         rgray_sync[0] <= rgray;
         for (int i = 1; i < NSYNC; i++)
            rgray_sync[i] <= rgray_sync[i-1];
      end
   end

   always_ff @(posedge wclk) begin
      if (wr_ok)
         mem[wbin[AW-1:0]] <= din;
   end

   // ====================
   // read domain
   // ====================

   assign rd_ok    = rd_en && !empty;
   assign rbin_nxt = rbin + {{AW{1'b0}}, rd_ok};
   assign empty    = (rgray == wgray_sync[NSYNC-1]);

   always_ff @(posedge rclk) begin
      if (rst) begin
         rbin       <= '0;
         rgray      <= '0;
         data_valid <= 1'b0;
         for (int i = 0; i < NSYNC; i++)
            wgray_sync[i] <= '0;
      end else begin
         rbin       <= rbin_nxt;
         rgray      <= bin2gray(rbin_nxt);
         data_valid <= rd_ok;   // dout holds the popped record one cycle after rd_en
         wgray_sync[0] <= wgray;
         for (int i = 1; i < NSYNC; i++)
            wgray_sync[i] <= wgray_sync[i-1];
      end
   end

   always_ff @(posedge rclk) begin
      if (rd_ok)
         dout <= mem[rbin[AW-1:0]];
   end

   a_no_overflow : assert property (@(posedge wclk) disable iff (rst) wr_en |-> !full);
   a_no_underflow : assert property (@(posedge rclk) disable iff (rst) rd_en |-> !empty);

endmodule

/* source/strm_read_fifo.sv */
`include "strm_config.svh"

module strm_read_fifo (
   input  logic                      rst,
   input  logic                      wclk,
   input  logic                      wr,           // memory beat this cycle
   input  logic [31:0]               wadr,
   input  logic [`STRM_DAT_BITS-1:0] wdat,
   input  logic                      last_strip,
   input  logic                      rclk,
   output strm_pkg::strm_resp_t      resp,
   output logic [`STRM_FIFO_AW:0]    wr_count
);

   strm_pkg::strm_resp_t rec;        // record latched on the wclk side
   strm_pkg::strm_resp_t fifo_dout;
   logic                 empty;
   logic                 data_valid;

   // ====================
   // wclk side latch
   // ====================

   // ack doubles as the write enable for the FIFO in the next cycle
   always_ff @(posedge wclk) begin
      if (rst) begin
         rec.ack <= 1'b0;
      end else begin
         rec.ack <= wr;
         if (wr) begin
            rec.last <= last_strip;
            rec.tid  <= `STRM_TID;   // single master, tranid 0 marks a burst response
            rec.adr  <= wadr;
            rec.dat  <= wdat;
         end
      end
   end

   strm_async_fifo u_fifo (
      .rst        (rst),
      .wclk       (wclk),
      .wr_en      (rec.ack),
      .din        (rec),
      .rclk       (rclk),
      .rd_en      (!empty),          // the consumer never stalls so drain as fast as possible
      .full       (),
      .wr_count   (wr_count),
      .empty      (empty),
      .dout       (fifo_dout),
      .data_valid (data_valid)
   );

   // rclk output register, ack is high for the one cycle after each pop
   always_ff @(posedge rclk) begin
      if (data_valid)
         resp <= fifo_dout;
      if (rst)
         resp.ack <= 1'b0;
      else
         resp.ack <= data_valid & fifo_dout.ack;
   end

endmodule

/* source/strm_read_channel.sv */
`include "strm_config.svh"

module strm_read_channel (
   input  logic                      rst,
   input  logic                      wclk,
   input  logic                      rclk,
   input  logic                      req_valid,
   input  strm_pkg::strm_req_t       req,
   input  logic                      mem_valid,
   input  logic [`STRM_DAT_BITS-1:0] mem_dat,
   output logic                      mem_rd,
   output logic [31:0]               mem_adr,
   output logic                      busy,
   output strm_pkg::strm_resp_t      resp
);

   logic                   load;
   logic                   issue;
   logic                   issue_left_zero;
   logic                   ret_left_zero;
   logic [`STRM_FIFO_AW:0] in_flight;
   logic [`STRM_FIFO_AW:0] wr_count;
   logic [31:0]            ret_adr;
   logic                   last_strip;

   // sequencer paces the reads, counter tracks what is out and what came back
   strm_strip_seq u_seq (
      .rst (rst), .wclk (wclk), .req_valid (req_valid), .req (req),
      .in_flight (in_flight), .wr_count (wr_count),
      .issue_left_zero (issue_left_zero), .ret_left_zero (ret_left_zero),
      .mem_valid (mem_valid), .load (load), .issue (issue),
      .mem_rd (mem_rd), .mem_adr (mem_adr), .busy (busy)
   );

   strm_strip_cnt u_cnt (
      .rst (rst), .wclk (wclk), .load (load), .req (req), .issue (issue),
      .mem_valid (mem_valid), .issue_left_zero (issue_left_zero),
      .ret_left_zero (ret_left_zero), .in_flight (in_flight),
      .ret_adr (ret_adr), .last_strip (last_strip)
   );

   // returned strips cross into rclk here
   strm_read_fifo u_rfifo (
      .rst (rst), .wclk (wclk), .wr (mem_valid), .wadr (ret_adr), .wdat (mem_dat),
      .last_strip (last_strip), .rclk (rclk), .resp (resp), .wr_count (wr_count)
   );

endmodule

/* testbench/tb_strm_read_channel.sv */
`include "strm_config.svh"

module tb_strm_read_channel;

   logic                      rst;
   logic                      wclk = 1'b0;
   logic                      rclk = 1'b0;
   logic                      req_valid;
   strm_pkg::strm_req_t       req;
   logic                      mem_valid = 1'b0;   // owned by the memory model
   logic [`STRM_DAT_BITS-1:0] mem_dat = '0;
   logic                      mem_rd;
   logic [31:0]               mem_adr;
   logic                      busy;
   strm_pkg::strm_resp_t      resp;

   strm_pkg::strm_resp_t exp_q [$];    // records still owed to the consumer, oldest first
   logic [31:0]          rd_adr_q [$]; // reads waiting inside the memory model
   int                   rd_due_q [$]; // wclk cycle on which each read answers
   logic [31:0]          lcg_state = 32'h1b76;
   int                   wcyc = 0;
   int                   due;
   int                   last_due = 0;
   int                   errors = 0;
   int                   err_mark = 0;
   int                   got_cnt = 0;
   int                   tests_run = 0;
   int                   tests_failed = 0;
   string                cur_test = "reset";

   strm_read_channel dut0 (
      .rst (rst), .wclk (wclk), .rclk (rclk), .req_valid (req_valid), .req (req),
      .mem_valid (mem_valid), .mem_dat (mem_dat), .mem_rd (mem_rd), .mem_adr (mem_adr),
      .busy (busy), .resp (resp)
   );

   always #10 rclk = ~rclk;   // consumer clock, period 20
   always #7 wclk = ~wclk;    // memory clock, period 14, unrelated to rclk

   // ====================
   // models
   // ====================

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // fixed hash so every address holds a distinct word
   function automatic logic [63:0] mem_word(input logic [31:0] adr);
      return {adr * 32'h9e37_79b9, adr ^ 32'hc3a5_5a3c};
   endfunction

   // record k of a stream as the consumer should see it
   function automatic strm_pkg::strm_resp_t expect_rec(input logic [31:0] base,
                                                       input int strips, input int k);
      strm_pkg::strm_resp_t r;
      r.ack  = 1'b1;
      r.last = (k == strips - 1);   // only the final strip closes the stream
      r.tid  = `STRM_TID;
      r.adr  = base + 32'(k * 8);
      r.dat  = mem_word(r.adr);
      return r;
   endfunction

   // memory answers in order, each read 1 to 6 wclk cycles after it was issued
   always @(posedge wclk) begin
      wcyc++;
      if (rst === 1'b1) begin
         rd_adr_q.delete();         // a reset loses whatever memory still owed
         rd_due_q.delete();
         last_due = wcyc;
      end else if (mem_rd === 1'b1) begin
         due = wcyc + int'((lcg_next() >> 16) % 32'd6);
         if (due <= last_due)
            due = last_due + 1;     // keep the answers in order, one per cycle
         last_due = due;
         rd_adr_q.push_back(mem_adr);
         rd_due_q.push_back(due);
      end
      #2;
      if (rd_due_q.size() != 0 && rd_due_q[0] <= wcyc) begin
         mem_valid = 1'b1;
         mem_dat   = mem_word(rd_adr_q.pop_front());
         void'(rd_due_q.pop_front());
      end else begin
         mem_valid = 1'b0;
      end
   end

   // ====================
   // checking
   // ====================

   task automatic check_eq(input string what, input logic [127:0] expected,
                           input logic [127:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("ERROR %s expected %h actual %h", what, expected, actual);
      end
   endtask

   // every valid record must match the oldest one still owed
   always @(posedge rclk) begin
      if (rst === 1'b0 && resp.ack === 1'b1) begin
         got_cnt++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("%s: a record for address %h arrived when none was owed",
                     cur_test, resp.adr);
         end else begin
            check_eq({cur_test, " record"}, 128'(exp_q.pop_front()), 128'(resp));
         end
      end
   end

   // ====================
   // stimulus helpers
   // ====================

   // one strobe, owed records are queued only when the request should be taken
   task automatic send_req(input logic [31:0] base, input int strips, input bit accept);
      int k;
      @(posedge wclk);
      #2;
      req_valid  = 1'b1;
      req.adr    = base;
      req.strips = strips[`STRM_CNT_BITS-1:0];
      @(posedge wclk);
      #2;
      req_valid = 1'b0;
      if (accept)
         for (k = 0; k < strips; k++)
            exp_q.push_back(expect_rec(base, strips, k));
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy !== 1'b0 && n < 2000) begin
         @(posedge wclk);
         n++;
      end
      if (busy !== 1'b0) begin
         errors++;
         $display("%s: busy never went low", cur_test);
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 3000) begin
         @(posedge rclk);
         n++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("%s: timed out with %0d records missing", cur_test, exp_q.size());
      end
      wait_idle();
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      err_mark = errors;
      got_cnt  = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == err_mark) begin
         $display("test %s ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s FAILED with %0d errors", cur_test, errors - err_mark);
      end
   endtask

   // ====================
   // test sequence
   // ====================

   initial begin
      int n;
      rst       = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      repeat (4) @(posedge rclk);
      #2;
      rst = 1'b0;

      start_test("single_strip");
      send_req(32'h0000_1000, 1, 1'b1);
      wait_drained();
      repeat (20) @(posedge rclk);        // a stray second record would show up by now
      check_eq({cur_test, " record count"}, 128'd1, 128'(got_cnt));
      finish_test();

      start_test("five_strips");
      send_req(32'h2000_0040, 5, 1'b1);
      wait_drained();
      check_eq({cur_test, " record count"}, 128'd5, 128'(got_cnt));
      finish_test();

      // longer than the FIFO so the credit limit has to throttle the reads
      start_test("long_stream");
      send_req(32'h0000_8000, 40, 1'b1);
      wait_drained();
      check_eq({cur_test, " record count"}, 128'd40, 128'(got_cnt));
      finish_test();

      start_test("req_while_busy");
      send_req(32'h0000_3000, 6, 1'b1);
      send_req(32'h0000_9000, 3, 1'b0);   // lands while the first stream runs
      wait_drained();
      repeat (60) @(posedge rclk);        // room for a wrongly taken stream to show up
      check_eq({cur_test, " record count"}, 128'd6, 128'(got_cnt));
      finish_test();

      start_test("back_to_back");
      send_req(32'h0000_4000, 3, 1'b1);
      wait_idle();
      send_req(32'h0000_5000, 4, 1'b1);
      wait_idle();
      send_req(32'h0000_6000, 2, 1'b1);
      wait_drained();
      check_eq({cur_test, " record count"}, 128'd9, 128'(got_cnt));
      finish_test();

      start_test("reset_mid_stream");
      send_req(32'h0000_7000, 30, 1'b1);
      n = 0;
      while (got_cnt < 3 && n < 500) begin
         @(posedge rclk);
         n++;
      end
      if (got_cnt < 3) begin
         errors++;
         $display("%s: the stream never started before the reset", cur_test);
      end
      @(posedge rclk);
      #2;
      rst = 1'b1;
      repeat (4) @(posedge rclk);
      #2;
      exp_q.delete();                     // the interrupted stream is gone
      rst = 1'b0;
      repeat (2) @(posedge rclk);
      check_eq({cur_test, " busy"}, 128'd0, 128'(busy));
      check_eq({cur_test, " mem_rd"}, 128'd0, 128'(mem_rd));
      check_eq({cur_test, " resp.ack"}, 128'd0, 128'(resp.ack));
      got_cnt = 0;
      send_req(32'h0000_a000, 4, 1'b1);
      wait_drained();
      check_eq({cur_test, " record count"}, 128'd4, 128'(got_cnt));
      finish_test();

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+source
source/strm_pkg.sv
source/strm_strip_cnt.sv
source/strm_strip_seq.sv
source/strm_async_fifo.sv
source/strm_read_fifo.sv
source/strm_read_channel.sv
testbench/tb_strm_read_channel.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_strm_read_channel
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
